//--- test/card_bus_checker.sv
`timescale 1ns/1ps
`default_nettype none

module card_bus_checker (
    input  wire logic               clock,
    input  wire logic               rst_n,
    input  wire logic               start,
    input  wire cmd_pkg::cmd_req_t  cmd,
    input  wire logic               busy,
    input  wire logic               done,
    input  wire cmd_pkg::cmd_resp_t resp,
    input  wire pbus_pkg::board_t   board,
    input  wire pbus_pkg::port_t    addr,
    input  wire logic               rd_n,
    input  wire logic               wr_n,
    input  wire logic               data_dir,
    input  wire logic [7:0]         data_out,
    output int                      errors,
    output int                      tests
);

    import pbus_pkg::*;
    import cmd_pkg::*;

    bus_step_t exp_q [$];   // Steps still owed by the open command
    cmd_resp_t exp_resp;
    cmd_kind_t open_kind;
    logic      open_cmd;
    logic      start_q;     // Accepted start last cycle
    logic      done_q;
    logic      strobe_q;    // A strobe was low last cycle
    board_t    setup_board; // Address seen before the strobe fell
    port_t     setup_addr;
    int        cmd_errs;

    initial begin
        errors = 0;
        tests  = 0;
    end

    // Card answer is board*16 + addr xor A5
    function automatic logic [7:0] card_byte(board_t b, port_t p);
        return (({4'h0, b} << 4) + {5'h0, p}) ^ 8'hA5;
    endfunction

    task automatic mismatch(string name, logic [7:0] got, logic [7:0] exp);
        $display("ERR %s: got %h expected %h", name, got, exp);
        errors++;
        cmd_errs++;
    endtask

    task automatic fail(string what);
        $display("Error: %s", what);
        errors++;
        cmd_errs++;
    endtask

    // Expected bus steps and response from the command rules
    task automatic expect_cmd(cmd_req_t c);
        bus_step_t s;
        int        b;
        exp_q.delete();
        exp_resp = '0;
        s        = '0;
        if (c.kind == CMD_ADC4) begin
            s.kind  = STEP_WRITE;   // Channel broadcast
            s.board = BOARD_ALL;
            s.port  = PORT_MUX;
            s.data  = c.data[0];
            exp_q.push_back(s);
            s.kind  = STEP_STROBE;  // Convert pulse with the bus undriven
            s.data  = '0;
            exp_q.push_back(s);
        end
        for (b = 1; b <= 4; b++) begin
            s.board = board_t'(b);
            if (c.kind == CMD_WRITE4) begin
                s.kind = STEP_WRITE;
                s.port = c.port;
                s.data = c.data[b-1];
                exp_q.push_back(s);
            end else if (c.kind == CMD_READ4) begin
                s.kind = STEP_READ;
                s.port = c.port;
                s.data = '0;
                exp_q.push_back(s);
                exp_resp.bytes[exp_resp.count] = card_byte(s.board, c.port);
                exp_resp.count++;
            end else begin
                s.kind = STEP_READ;
                s.port = PORT_ADC_HIGH;     // High byte first
                exp_q.push_back(s);
                exp_resp.bytes[exp_resp.count] = card_byte(s.board, PORT_ADC_HIGH);
                exp_resp.count++;
                s.port = PORT_ADC_LOW;
                exp_q.push_back(s);
                exp_resp.bytes[exp_resp.count] = card_byte(s.board, PORT_ADC_LOW);
                exp_resp.count++;
            end
        end
    endtask

    // Compare the first strobe cycle against the next owed step
    task automatic check_strobe();
        bus_step_t s;
        if (exp_q.size() == 0) begin
            fail("extra bus step, no step was expected");
        end else begin
            s = exp_q.pop_front();
            if (rd_n != (s.kind != STEP_READ)) mismatch("rd_n", rd_n, s.kind != STEP_READ);
            if (wr_n != (s.kind == STEP_READ)) mismatch("wr_n", wr_n, s.kind == STEP_READ);
            if (board != s.board) mismatch("board", board, s.board);
            if (addr != s.port) mismatch("addr", addr, s.port);
            if (data_dir != (s.kind == STEP_WRITE))
                mismatch("data_dir", data_dir, s.kind == STEP_WRITE);
            if (s.kind == STEP_WRITE && data_out != s.data)
                mismatch("data_out", data_out, s.data);
        end
    endtask

    task automatic close_cmd();
        int i;
        if (!open_cmd) begin
            fail("done with no command open");
        end else begin
            if (exp_q.size() != 0)
                fail($sformatf("%0d bus steps missing at done", exp_q.size()));
            if (!busy) mismatch("busy", busy, 1'b1);
            if (resp.count != exp_resp.count) mismatch("resp.count", resp.count, exp_resp.count);
            for (i = 0; i < 8; i++) begin
                if (resp.bytes[i] != exp_resp.bytes[i])
                    mismatch($sformatf("resp.bytes[%0d]", i), resp.bytes[i], exp_resp.bytes[i]);
            end
            $display("cmd %0d %s: %0d errors", tests, open_kind.name(), cmd_errs);
            tests++;
            open_cmd = 1'b0;
        end
    endtask

    always @(posedge clock) begin
        if (!rst_n) begin
            exp_q.delete();
            open_cmd = 1'b0;
            start_q  = 1'b0;
            done_q   = 1'b0;
            strobe_q = 1'b0;
            cmd_errs = 0;
        end else begin
            if (!rd_n && !wr_n) fail("rd_n and wr_n low together");
            if (!rd_n || !wr_n) begin
                if (!strobe_q) check_strobe();
                if (board != setup_board) mismatch("board in strobe", board, setup_board);
                if (addr != setup_addr) mismatch("addr in strobe", addr, setup_addr);
            end else begin
                setup_board = board;
                setup_addr  = addr;
            end
            strobe_q = !rd_n || !wr_n;
            if (start_q && !busy) mismatch("busy after start", busy, 1'b1);
            if (done_q && busy) mismatch("busy after done", busy, 1'b0);
            if (done) close_cmd();
            if (start && !busy) begin
                open_cmd  = 1'b1;
                open_kind = cmd.kind;
                cmd_errs  = 0;
                expect_cmd(cmd);
            end
            start_q = start && !busy;
            done_q  = done;
        end
    end

endmodule

`default_nettype wire

//--- test/card_bus_tb.sv
`timescale 1ns/1ps
`default_nettype none

module card_bus_tb;

    import pbus_pkg::*;
    import cmd_pkg::*;

    localparam int WAIT   = 3;   // Short slots keep the run brief
    localparam int N_CMDS = 8;

    // Table row with the bus step count the command must produce
    typedef struct packed {
        cmd_kind_t  kind;
        port_t      port;
        logic [3:0] steps;
    } entry_t;

    logic        clock;
    logic        rst_n;
    logic        start;
    cmd_req_t    cmd;
    logic        busy;
    logic        done;
    cmd_resp_t   resp;
    board_t      board;
    port_t       addr;
    logic        rd_n;
    logic        wr_n;
    logic [7:0]  data_out;
    logic [7:0]  data_in;
    logic        data_dir;
    logic [15:0] lfsr;
    int          errors;
    int          tests;
    int          cycles = 0;
    int          limit  = 200;   // Slack for reset and command gaps

    // Card model answers from the latched address
    assign data_in = (({4'h0, board} << 4) + {5'h0, addr}) ^ 8'hA5;

    card_bus_top #(.WAIT_CYCLES(WAIT)) u_dut (
        .clock, .rst_n, .start, .cmd, .busy, .done, .resp,
        .board, .addr, .rd_n, .wr_n, .data_out, .data_in, .data_dir
    );

    card_bus_checker u_check (
        .clock, .rst_n, .start, .cmd, .busy, .done, .resp,
        .board, .addr, .rd_n, .wr_n, .data_dir, .data_out,
        .errors, .tests
    );

    function automatic entry_t stim_entry(int i);
        case (i)
            0:       return '{CMD_WRITE4, 3'd1, 4'd4};
            1:       return '{CMD_READ4,  3'd2, 4'd4};
            2:       return '{CMD_ADC4,   3'd0, 4'd10};  // Port unused by adc4
            3:       return '{CMD_WRITE4, 3'd5, 4'd4};
            4:       return '{CMD_READ4,  3'd7, 4'd4};
            5:       return '{CMD_ADC4,   3'd4, 4'd10};
            6:       return '{CMD_READ4,  3'd0, 4'd4};
            default: return '{CMD_WRITE4, 3'd3, 4'd4};
        endcase
    endfunction

    // Fibonacci taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] b;
        b = '0;
        for (int k = 0; k < 8; k++) begin
            lfsr = lfsr_next(lfsr);   // One step per bit
            b    = {b[6:0], lfsr[0]};
        end
        return b;
    endfunction

    // Starts at a rising edge and returns at the edge that samples done
    task automatic run_cmd(entry_t e);
        cmd_req_t c;
        int       k;
        c.kind = e.kind;
        c.port = e.port;
        for (k = 0; k < 4; k++)
            c.data[k] = random_byte();
        #2;
        cmd   = c;
        start = 1'b1;
        @(posedge clock);
        #2;
        start = 1'b0;
        do
            @(posedge clock);
        while (!done);
    endtask

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Run limit from the table length
    always @(posedge clock) begin
        cycles++;
        if (cycles >= limit) begin
            $display("Timeout: run still going after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        int     i;
        entry_t e;
        rst_n = 1'b0;
        start = 1'b0;
        cmd   = '0;
        lfsr  = 16'd40;
        for (i = 0; i < N_CMDS; i++) begin
            e     = stim_entry(i);
            limit += 2 * e.steps * (3 * WAIT + 1);
        end
        repeat (5) @(posedge clock);
        #2;
        rst_n = 1'b1;
        @(posedge clock);
        for (i = 0; i < N_CMDS; i++)
            run_cmd(stim_entry(i));   // Back to back with the next start right after done
        repeat (3) @(posedge clock);
        $display("Commands %0d of %0d, errors %0d", tests, N_CMDS, errors);
        if (errors == 0 && tests == N_CMDS)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
verilog/pbus_pkg.sv
verilog/cmd_pkg.sv
verilog/cmd_sequencer.sv
verilog/bus_fifo.sv
verilog/phase_bus_engine.sv
verilog/response_gather.sv
verilog/card_bus_top.sv
test/card_bus_checker.sv
test/card_bus_tb.sv

//--- verilog/bus_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module bus_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  wire logic     clock,
    input  wire logic     rst_n,
    input  wire logic     push,
    input  wire payload_t wdata,
    output      logic     full,
    input  wire logic     pop,
    output      payload_t rdata,
    output      logic     empty
);

    localparam int AW = $clog2(DEPTH);

    payload_t      mem [DEPTH];
    logic [AW:0]   wr_ptr;  // MSB is the wrap bit
    logic [AW:0]   rd_ptr;
    logic          do_push;
    logic          do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Same index, opposite lap means full
    assign empty = wr_ptr == rd_ptr;
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign rdata = mem[rd_ptr[AW-1:0]]; // Head visible without a pop

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (do_push) mem[wr_ptr[AW-1:0]] <= wdata;
    end

    initial begin
        a_depth: assert (DEPTH >= 2 && (DEPTH & (DEPTH - 1)) == 0)
            else $fatal(1, "DEPTH must be a power of two, at least 2");
    end

    // A push refused by full has to be offered again unchanged
    a_no_overflow: assert property (
        @(posedge clock) disable iff (!rst_n)
        push && full |=> push && $stable(wdata)
    ) else $error("push lost while full");

    a_no_underflow: assert property (
        @(posedge clock) disable iff (!rst_n) pop |-> !empty
    ) else $error("pop while empty");

endmodule

`default_nettype wire

//--- verilog/card_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module card_bus_top #(
    parameter int WAIT_CYCLES = pbus_pkg::WAIT_CYCLES_DEFAULT,
    parameter int STEP_DEPTH  = 4,
    parameter int READ_DEPTH  = 8   // Holds a full adc4 result
) (
    input  wire logic               clock,
    input  wire logic               rst_n,
    input  wire logic               start,
    input  wire cmd_pkg::cmd_req_t  cmd,
    output      logic               busy,
    output      logic               done,
    output      cmd_pkg::cmd_resp_t resp,
    output      pbus_pkg::board_t   board,
    output      pbus_pkg::port_t    addr,
    output      logic               rd_n,
    output      logic               wr_n,
    output      logic [7:0]         data_out,
    input  wire logic [7:0]         data_in,
    output      logic               data_dir
);

    import pbus_pkg::*;

    bus_step_t  seq_step;
    bus_step_t  head_step;
    logic       step_push, step_full, step_pop, step_empty;
    logic       rd_push, rd_pop, rd_empty;
    logic [7:0] rd_data, rd_byte;
    logic       cmd_end;

    cmd_sequencer u_seq (
        .clock, .rst_n, .start, .cmd, .busy,
        .step_push, .step(seq_step), .step_full,
        .cmd_done(done)                          // Gatherer closes the command
    );

    bus_fifo #(.payload_t(bus_step_t), .DEPTH(STEP_DEPTH)) u_step_fifo (
        .clock, .rst_n,
        .push(step_push), .wdata(seq_step), .full(step_full),
        .pop(step_pop), .rdata(head_step), .empty(step_empty)
    );

    phase_bus_engine #(.WAIT_CYCLES(WAIT_CYCLES)) u_engine (
        .clock, .rst_n,
        .step_pop, .step(head_step), .step_empty,
        .board, .addr, .rd_n, .wr_n, .data_dir, .data_out, .data_in,
        .rd_push, .rd_data, .cmd_end
    );

    bus_fifo #(.payload_t(logic [7:0]), .DEPTH(READ_DEPTH)) u_read_fifo (
        .clock, .rst_n,
        .push(rd_push), .wdata(rd_data), .full(),
        .pop(rd_pop), .rdata(rd_byte), .empty(rd_empty)
    );

    response_gather u_gather (
        .clock, .rst_n, .start, .kind(cmd.kind),
        .rd_pop, .rd_byte, .rd_empty, .cmd_end, .done, .resp
    );

endmodule

`default_nettype wire

//--- verilog/cmd_pkg.sv
`default_nettype none

package cmd_pkg;

    typedef enum logic [1:0] {
        CMD_WRITE4 = 2'd0,
        CMD_READ4  = 2'd1,
        CMD_ADC4   = 2'd2
    } cmd_kind_t;

    localparam int RESP_BYTES = 8; // adc4 returns high and low per card

    // Host request, data[0] doubles as the mux channel for adc4
    typedef struct packed {
        cmd_kind_t       kind;
        pbus_pkg::port_t port;
        logic [3:0][7:0] data;
    } cmd_req_t;

    // Response, bytes past count are zero
    typedef struct packed {
        logic [3:0]      count;
        logic [7:0][7:0] bytes;
    } cmd_resp_t;

    // Number of bytes a command reads back
    function automatic logic [3:0] resp_count(cmd_kind_t kind);
        case (kind)
            CMD_READ4: return 4'd4;
            CMD_ADC4:  return 4'd8;
            default:   return 4'd0;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- verilog/cmd_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_sequencer (
    input  wire logic                clock,
    input  wire logic                rst_n,
    input  wire logic                start,
    input  wire cmd_pkg::cmd_req_t   cmd,
    output      logic                busy,
    output      logic                step_push,
    output      pbus_pkg::bus_step_t step,
    input  wire logic                step_full,
    input  wire logic                cmd_done
);

    import pbus_pkg::*;
    import cmd_pkg::*;

    cmd_req_t   cmd_q;    // Command under expansion
    logic [3:0] step_idx; // Index into the step list, adc4 runs 0..9
    logic [3:0] adc_idx;  // Read index within adc4

    logic accept;
    assign accept = start && !busy; // Start while busy is dropped

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            step_push <= 1'b0;
            step_idx  <= '0;
        end else begin
            if (accept) begin
                busy      <= 1'b1;
                step_push <= 1'b1;
                step_idx  <= '0;
            end else begin
                if (step_push && !step_full) begin // Step taken by FIFO
                    if (step.last)
                        step_push <= 1'b0;
                    else
                        step_idx <= step_idx + 4'd1;
                end
                if (cmd_done) busy <= 1'b0; // Gatherer finished
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) cmd_q <= cmd;
    end

    // Step decode from latched command and index
    always_comb begin
        adc_idx = step_idx - 4'd2; // Skips mux write and convert pulse
        step    = '0;
        case (cmd_q.kind)
            CMD_WRITE4: begin
                step.kind  = STEP_WRITE;
                step.board = step_idx + 4'd1;      // Boards 1..4 in turn
                step.port  = cmd_q.port;
                step.data  = cmd_q.data[step_idx[1:0]];
                step.last  = step_idx == 4'd3;
            end
            CMD_READ4: begin
                step.kind  = STEP_READ;
                step.board = step_idx + 4'd1;
                step.port  = cmd_q.port;
                step.last  = step_idx == 4'd3;
            end
            default: begin
                if (step_idx == 4'd0) begin
                    step.kind  = STEP_WRITE;   // Mux channel to every card
                    step.board = BOARD_ALL;
                    step.port  = PORT_MUX;
                    step.data  = cmd_q.data[0];
                end else if (step_idx == 4'd1) begin
                    step.kind  = STEP_STROBE;  // Conversion start
                    step.board = BOARD_ALL;
                    step.port  = PORT_MUX;
                end else begin
                    // High then low byte per card
                    step.kind  = STEP_READ;
                    step.board = {2'b00, adc_idx[2:1]} + 4'd1;
                    step.port  = adc_idx[0] ? PORT_ADC_LOW : PORT_ADC_HIGH;
                    step.last  = step_idx == 4'd9;
                end
            end
        endcase
    end

    // Host must wait for done before the next command
    a_no_start_busy: assert property (
        @(posedge clock) disable iff (!rst_n) start |-> !busy
    ) else $error("start while busy");

    // Back-pressure holds the offered step
    a_step_hold: assert property (
        @(posedge clock) disable iff (!rst_n)
        step_push && step_full |=> step_push && $stable(step)
    ) else $error("step changed under full");

endmodule

`default_nettype wire

//--- verilog/pbus_pkg.sv
`default_nettype none

package pbus_pkg;

    // Card select code on the backplane
    typedef logic [3:0] board_t;

    localparam board_t BOARD_NONE = 4'd0; // Idle value after reset
    localparam board_t BOARD_1    = 4'd1;
    localparam board_t BOARD_2    = 4'd2;
    localparam board_t BOARD_3    = 4'd3;
    localparam board_t BOARD_4    = 4'd4;
    localparam board_t BOARD_ALL  = 4'd5; // Broadcast, every card latches

    // Register port on a card
    typedef logic [2:0] port_t;

    localparam port_t PORT_MUX      = 3'd3; // Analog mux channel latch
    localparam port_t PORT_ADC_HIGH = 3'd6;
    localparam port_t PORT_ADC_LOW  = 3'd7;

    typedef enum logic [1:0] {
        STEP_WRITE  = 2'd0,
        STEP_READ   = 2'd1,
        STEP_STROBE = 2'd2  // Write pulse, data bus left undriven
    } step_kind_t;

    // One single bus access
    typedef struct packed {
        step_kind_t kind;
        board_t     board;
        port_t      port;
        logic [7:0] data;  // Write byte, zero for reads and strobes
        logic       last;  // Final step of its command
    } bus_step_t;

    localparam int WAIT_CYCLES_DEFAULT = 21; // ~750 ns slot at 27 MHz

endpackage

`default_nettype wire

//--- verilog/phase_bus_engine.sv
`timescale 1ns/1ps
`default_nettype none

module phase_bus_engine #(
    parameter int WAIT_CYCLES = 21
) (
    input  wire logic                clock,
    input  wire logic                rst_n,
    output      logic                step_pop,
    input  wire pbus_pkg::bus_step_t step,
    input  wire logic                step_empty,
    output      pbus_pkg::board_t    board,
    output      pbus_pkg::port_t     addr,
    output      logic                rd_n,
    output      logic                wr_n,
    output      logic                data_dir,
    output      logic [7:0]          data_out,
    input  wire logic [7:0]          data_in,
    output      logic                rd_push,
    output      logic [7:0]          rd_data,
    output      logic                cmd_end
);

    import pbus_pkg::*;

    localparam int            CW        = $clog2(WAIT_CYCLES + 1);
    localparam logic [CW-1:0] SLOT_LAST = CW'(WAIT_CYCLES - 1);

    typedef enum logic [1:0] {
        IDLE,
        SETUP,   // Address settles with strobes high
        STROBE,  // rd_n or wr_n low
        RELEASE  // Strobes high while data is still held
    } state_t;

    state_t        state;
    logic [CW-1:0] slot_cnt;
    logic          slot_end;
    bus_step_t     step_q;   // Step in flight

    assign slot_end = slot_cnt == SLOT_LAST;

    // Take the head step only from idle
    assign step_pop = (state == IDLE) && !step_empty;

    // Sample the card on the last strobe cycle
    assign rd_push = (state == STROBE) && slot_end && (step_q.kind == STEP_READ);
    assign rd_data = data_in;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state    <= IDLE;
            slot_cnt <= '0;
            board    <= BOARD_NONE;
            addr     <= '0;
            rd_n     <= 1'b1;
            wr_n     <= 1'b1;
            data_dir <= 1'b0;
            cmd_end  <= 1'b0;
        end else begin
            cmd_end <= 1'b0;
            if (state != IDLE)
                slot_cnt <= slot_end ? '0 : slot_cnt + 1'b1;

            case (state)
                IDLE: begin
                    if (!step_empty) begin
                        board    <= step.board;
                        addr     <= step.port;
                        data_dir <= step.kind == STEP_WRITE; // Strobe leaves bus free
                        state    <= SETUP;
                    end
                end
                SETUP: begin
                    if (slot_end) begin
                        wr_n  <= step_q.kind == STEP_READ;   // Low for write and strobe
                        rd_n  <= step_q.kind != STEP_READ;
                        state <= STROBE;
                    end
                end
                STROBE: begin
                    if (slot_end) begin
                        rd_n  <= 1'b1;
                        wr_n  <= 1'b1;
                        state <= RELEASE;
                    end
                end
                default: begin
                    if (slot_end) begin
                        data_dir <= 1'b0;        // Hand the bus back
                        cmd_end  <= step_q.last;
                        state    <= IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (step_pop) begin
            step_q   <= step;
            data_out <= step.data;
        end
    end

    a_strobe_excl: assert property (
        @(posedge clock) disable iff (!rst_n) !(!rd_n && !wr_n)
    ) else $error("rd_n and wr_n low together");

endmodule

`default_nettype wire

//--- verilog/response_gather.sv
`timescale 1ns/1ps
`default_nettype none

module response_gather (
    input  wire logic               clock,
    input  wire logic               rst_n,
    input  wire logic               start,
    input  wire cmd_pkg::cmd_kind_t kind,
    output      logic               rd_pop,
    input  wire logic [7:0]         rd_byte,
    input  wire logic               rd_empty,
    input  wire logic               cmd_end,
    output      logic               done,
    output      cmd_pkg::cmd_resp_t resp
);

    import cmd_pkg::*;

    cmd_kind_t       kind_q;
    logic            pending;  // Command open
    logic            ended;    // Engine finished the last step
    logic [3:0]      count;
    logic [7:0][7:0] bytes_q;
    logic            finish;

    assign rd_pop = !rd_empty;   // Drain as bytes arrive
    assign finish = ended && (count == resp_count(kind_q)) && !rd_pop;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pending <= 1'b0;
            ended   <= 1'b0;
            count   <= '0;
            bytes_q <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start && !pending) pending <= 1'b1;
            if (rd_pop) begin
                bytes_q[count[2:0]] <= rd_byte; // Arrival order
                count               <= count + 4'd1;
            end
            if (cmd_end) ended <= 1'b1;
            if (finish) begin
                done    <= 1'b1;
                pending <= 1'b0;
                ended   <= 1'b0;
                count   <= '0;
                bytes_q <= '0;  // Unused bytes read back as zero
            end
        end
    end

    always_ff @(posedge clock) begin
        if (start && !pending) kind_q <= kind;
        if (finish) begin
            resp.count <= count;
            resp.bytes <= bytes_q;
        end
    end

    a_count_max: assert property (
        @(posedge clock) disable iff (!rst_n) count <= 4'(RESP_BYTES)
    ) else $error("response byte count over 8");

    a_end_open: assert property (
        @(posedge clock) disable iff (!rst_n) cmd_end |-> pending
    ) else $error("cmd_end without open command");

endmodule

`default_nettype wire
